// File: src.f
+incdir+verification
design/fe_pkg.sv
design/fe_pc_gen.sv
design/fe_instr_store.sv
design/fe_jump_resolve.sv
design/fe_issue_buffer.sv
design/fe_top.sv
verification/fe_props.sv
verification/fe_tb.sv

// File: verification/fe_tb_tests.svh
//////////////////////////////////////////////////////////////////////
// stimulus building blocks
//////////////////////////////////////////////////////////////////////

task automatic write_word(input logic [addr_w-1:0] a, input logic [insn_w-1:0] d);
   @(negedge clk);
   prog_we   = 1'b1;
   prog_addr = a;
   prog_data = d;
   img[a[store_aw-1:0]] = d;
endtask

// target = pc + 1 + offset
task automatic put_imm(input logic [addr_w-1:0] pc, input logic [addr_w-1:0] target);
   logic [addr_w-1:0] off;
   off = target - pc - addr_w'(1);
   write_word(pc, {op_jump, off[imm_off_w-1:0], 2'b00});
endtask

task automatic put_reg(input logic [addr_w-1:0] pc, input logic [3:0] idx,
                       input logic [5:0] off);
   write_word(pc, {op_jump, idx, off, 2'b01});
endtask

task automatic restart(input logic [addr_w-1:0] pc);
   @(negedge clk);
   prog_we          = 1'b0;
   mispredict_valid = 1'b1;
   mispredict_pc    = pc;
   rx_q.delete();
   req_log.delete();
   @(negedge clk);
   mispredict_valid = 1'b0;
endtask

// walk the program by the format rules
task automatic build_expected(input logic [addr_w-1:0] start, input int n);
   logic [addr_w-1:0] pc;
   logic [insn_w-1:0] w;
   logic [addr_w-1:0] off;
   exp_q.delete();
   exp_regs.delete();
   pc = start;
   for (int i = 0; i < n; i++) begin
      w = img[pc[store_aw-1:0]];
      exp_q.push_back({pc, w});
      if (w[op_lo +: op_w] == op_jump && w[kind_bit]) begin
         off = {{(addr_w - reg_off_w){w[reg_off_lo + reg_off_w - 1]}},
                w[reg_off_lo +: reg_off_w]};
         if (i < n - 1) begin
            exp_regs.push_back(w[reg_idx_lo +: reg_idx_w]);
         end
         pc = regs[w[reg_idx_lo +: reg_idx_w]] + off;
      end else if (w[op_lo +: op_w] == op_jump) begin
         off = {{(addr_w - imm_off_w){w[imm_off_lo + imm_off_w - 1]}},
                w[imm_off_lo +: imm_off_w]};
         pc = pc + addr_w'(1) + off;
      end else begin
         pc = pc + addr_w'(1);
      end
   end
endtask

task automatic wait_slots(input int n, input string test);
   int t;
   t = 0;
   while (rx_q.size() < n) begin
      @(negedge clk);
      t++;
      if (t > 3000) begin
         fail_timeout({test, ": too few slots delivered"});
      end
   end
endtask

task automatic run_stream(input string test, input logic [addr_w-1:0] start, input int n);
   restart(start);
   build_expected(start, n);
   wait_slots(n, test);
   for (int i = 0; i < n; i++) begin
      check_value(test, exp_q[i], rx_q[i]);
   end
   if (req_log.size() < exp_regs.size()) begin
      fail_run({test, ": base request missing"});
   end
   for (int i = 0; i < exp_regs.size(); i++) begin
      check_value({test, " base_req_reg"}, 32'(exp_regs[i]), 32'(req_log[i]));
   end
endtask

//////////////////////////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////////////////////////

task automatic test_reset_and_straight();
   repeat (10) @(posedge clk);
   @(negedge clk);
   rst_n = 1'b1;
   check_value("reset out_valid", 32'd0, 32'(out_valid));
   check_value("reset base_req_valid", 32'd0, 32'(base_req_valid));
   // non-jump fill, word tied to its own address
   for (int a = 0; a < store_depth; a++) begin
      write_word(addr_w'(a), {8'h20, 8'(a)});
   end
   run_stream("straight", 16'h0000, 40);
endtask

task automatic test_imm_jumps();
   // forward jumps from slots 0 to 3
   put_imm(16'h0010, 16'h0021);
   put_imm(16'h0021, 16'h0032);
   put_imm(16'h0032, 16'h0043);
   put_imm(16'h0043, 16'h006c);
   // backward jumps from slots 0 to 3
   put_imm(16'h006c, 16'h005d);
   put_imm(16'h005d, 16'h004e);
   put_imm(16'h004e, 16'h003f);
   put_imm(16'h003f, 16'h0006);
   run_stream("imm_jumps", 16'h0010, 48);
endtask

task automatic test_reg_jumps();
   put_reg(16'h0081, 4'd3, 6'd2);
   put_reg(16'h0095, 4'd5, 6'h3d);
   put_reg(16'h00a7, 4'd9, 6'd0);
   run_stream("reg_jumps", 16'h0080, 60);
endtask

task automatic test_backpressure();
   rand_ready = 1'b1;
   run_stream("ready_imm", 16'h0010, 60);
   run_stream("ready_reg", 16'h0080, 60);
   rand_ready = 1'b0;
endtask

task automatic test_mispredict();
   int t;
   restart(16'h0080);
   t = 0;
   while (!base_req_valid) begin
      @(negedge clk);
      t++;
      if (t > 500) begin
         fail_timeout("mispredict: no base request seen");
      end
   end
   // flush while waiting on the base
   run_stream("flush_in_wait", 16'h0023, 40);
   restart(16'h0010);
   wait_slots(10, "flush_in_stream");
   run_stream("flush_in_stream", 16'h0085, 40);
endtask

// File: verification/fe_tb.sv
`timescale 1ns/1ps

module fe_tb;
   import fe_pkg::*;

   logic                  clk;
   logic                  rst_n;
   logic                  prog_we;
   logic [addr_w-1:0]     prog_addr;
   logic [insn_w-1:0]     prog_data;
   logic                  mispredict_valid;
   logic [addr_w-1:0]     mispredict_pc;
   logic                  base_req_valid;
   logic [reg_idx_w-1:0]  base_req_reg;
   logic                  base_rsp_valid;
   logic [addr_w-1:0]     base_rsp_data;
   fetch_bundle_t         out_bundle;
   logic                  out_valid;
   logic                  out_ready;

   // mirror of the store and the register file
   logic [insn_w-1:0]     img [store_depth];
   logic [addr_w-1:0]     regs [16];
   logic [31:0]           rng_state;
   // {pc, insn} per live slot
   logic [31:0]           rx_q [$];
   logic [31:0]           exp_q [$];
   logic [reg_idx_w-1:0]  req_log [$];
   logic [reg_idx_w-1:0]  exp_regs [$];
   logic                  rand_ready;
   logic                  rsp_busy;
   logic                  rsp_cancel;
   logic                  req_seen;
   int                    rsp_cnt;

   fe_top u_fe_top (
      .clk              (clk),
      .rst_n            (rst_n),
      .prog_we          (prog_we),
      .prog_addr        (prog_addr),
      .prog_data        (prog_data),
      .mispredict_valid (mispredict_valid),
      .mispredict_pc    (mispredict_pc),
      .base_req_valid   (base_req_valid),
      .base_req_reg     (base_req_reg),
      .base_rsp_valid   (base_rsp_valid),
      .base_rsp_data    (base_rsp_data),
      .out_bundle       (out_bundle),
      .out_valid        (out_valid),
      .out_ready        (out_ready)
   );

   bind fe_top fe_props u_fe_props (
      .clk              (clk),
      .rst_n            (rst_n),
      .mispredict_valid (mispredict_valid),
      .base_req_valid   (base_req_valid),
      .base_rsp_valid   (base_rsp_valid),
      .out_bundle       (out_bundle),
      .out_valid        (out_valid),
      .out_ready        (out_ready)
   );

   always #4 clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   task automatic check_value(input string test, input logic [31:0] exp,
                              input logic [31:0] act);
      if (exp !== act) begin
         $display("CHECK FAILED %s expected %h actual %h", test, exp, act);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic fail_timeout(input string what);
      fail_run({"timeout: ", what});
   endtask

   //////////////////////////////////////////////////////////////////////
   // decode side monitor and request log
   //////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      if (mispredict_valid) begin
         // stale response must not land after the flush
         rsp_cancel <= 1'b1;
      end else if (rst_n) begin
         if (out_valid && out_ready) begin
            for (int i = 0; i < fetch_width; i++) begin
               if (out_bundle.mask[i]) begin
                  rx_q.push_back({out_bundle.pc + addr_w'(i), out_bundle.insn[i]});
               end
            end
         end
         // new request seen on the rising edge of valid
         if (base_req_valid && !req_seen) begin
            req_log.push_back(base_req_reg);
         end
      end
      req_seen <= base_req_valid && !mispredict_valid;
   end

   // a failed bound assertion ends the run
   always @(negedge clk) begin
      if (u_fe_top.u_fe_props.fail_cnt != 0) begin
         fail_run("an assertion on the top level handshakes failed");
      end
   end

   //////////////////////////////////////////////////////////////////////
   // register file model and decode ready
   //////////////////////////////////////////////////////////////////////

   always @(negedge clk) begin
      logic [31:0] r;
      base_rsp_valid = 1'b0;
      if (rsp_cancel) begin
         rsp_busy   = 1'b0;
         rsp_cancel = 1'b0;
      end else if (rsp_busy) begin
         rsp_cnt = rsp_cnt - 1;
         if (rsp_cnt == 0) begin
            base_rsp_valid = 1'b1;
            base_rsp_data  = regs[base_req_reg];
            rsp_busy       = 1'b0;
         end
      end else if (base_req_valid) begin
         r        = next_rand();
         rsp_busy = 1'b1;
         // 1 to 6 cycles
         rsp_cnt  = 1 + int'(r % 6);
      end
      r = next_rand();
      out_ready = rand_ready ? r[3] : 1'b1;
   end

   `include "fe_tb_tests.svh"

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      clk              = 1'b0;
      rst_n            = 1'b0;
      prog_we          = 1'b0;
      prog_addr        = '0;
      prog_data        = '0;
      mispredict_valid = 1'b0;
      mispredict_pc    = '0;
      base_rsp_valid   = 1'b0;
      base_rsp_data    = '0;
      out_ready        = 1'b1;
      rng_state        = 32'd73;
      rand_ready       = 1'b0;
      rsp_busy         = 1'b0;
      rsp_cancel       = 1'b0;
      req_seen         = 1'b0;
      rsp_cnt          = 0;
      for (int i = 0; i < 16; i++) begin
         regs[i] = addr_w'(16'h40 + 4 * i);
      end
      regs[3] = 16'h0090;
      regs[5] = 16'h00a3;
      regs[9] = 16'h0080;
      test_reset_and_straight();
      test_imm_jumps();
      test_reg_jumps();
      test_backpressure();
      test_mispredict();
      @(negedge clk);
      if (u_fe_top.u_fe_props.fail_cnt != 0) begin
         fail_run("an assertion on the top level handshakes failed");
      end else begin
         $display("Test passed");
         $finish;
      end
   end

endmodule

// File: verification/fe_props.sv
`timescale 1ns/1ps

module fe_props (
   input logic                  clk,
   input logic                  rst_n,
   input logic                  mispredict_valid,
   input logic                  base_req_valid,
   input logic                  base_rsp_valid,
   input fe_pkg::fetch_bundle_t out_bundle,
   input logic                  out_valid,
   input logic                  out_ready
);

   // number of failed assertions so far
   int fail_cnt = 0;

   //////////////////////////////////////////////////////////////////////
   // decode side handshake
   //////////////////////////////////////////////////////////////////////

   // stalled bundle holds, a flush may drop it
   a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready && !mispredict_valid |=> out_valid && $stable(out_bundle))
      else begin
         $error("out_bundle changed while stalled");
         fail_cnt = fail_cnt + 1;
      end

   // nothing offered during reset
   a_out_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
      else begin
         $error("out_valid high in reset");
         fail_cnt = fail_cnt + 1;
      end

   //////////////////////////////////////////////////////////////////////
   // base request
   //////////////////////////////////////////////////////////////////////

   // request held until answered or flushed
   a_base_hold: assert property (@(posedge clk) disable iff (!rst_n)
      base_req_valid && !base_rsp_valid && !mispredict_valid |=> base_req_valid)
      else begin
         $error("base_req_valid dropped before response");
         fail_cnt = fail_cnt + 1;
      end

endmodule

// File: design/fe_top.sv
`timescale 1ns/1ps

module fe_top (
   input  logic                          clk,
   input  logic                          rst_n,
   // program load port
   input  logic                          prog_we,
   input  logic [fe_pkg::addr_w-1:0]     prog_addr,
   input  logic [fe_pkg::insn_w-1:0]     prog_data,
   // back end restart
   input  logic                          mispredict_valid,
   input  logic [fe_pkg::addr_w-1:0]     mispredict_pc,
   // register file base lookup
   output logic                          base_req_valid,
   output logic [fe_pkg::reg_idx_w-1:0]  base_req_reg,
   input  logic                          base_rsp_valid,
   input  logic [fe_pkg::addr_w-1:0]     base_rsp_data,
   // toward decode
   output fe_pkg::fetch_bundle_t         out_bundle,
   output logic                          out_valid,
   input  logic                          out_ready
);
   import fe_pkg::*;

   redirect_t         jr_redirect;
   redirect_t         mp_redirect;
   redirect_t         pc_redirect;
   logic              flush;
   logic              squash;
   logic              fetch_hold;
   logic              fetch_valid;
   logic              fetch_ready;
   logic [addr_w-1:0] fetch_pc;
   logic [slot_w-1:0] start_slot;
   fetch_bundle_t     st_bundle;
   logic              st_valid;
   logic              st_ready;
   fetch_bundle_t     jr_bundle;
   logic              jr_valid;
   logic              jr_ready;

   //////////////////////////////////////////////////////////////////////
   // redirect select
   //////////////////////////////////////////////////////////////////////

   // mispredict flushes every stage
   assign flush       = mispredict_valid;
   assign mp_redirect = '{valid: mispredict_valid, pc: mispredict_pc};
   // back end wins over a jump found in fetch
   assign pc_redirect = mispredict_valid ? mp_redirect : jr_redirect;

   //////////////////////////////////////////////////////////////////////
   // stages
   //////////////////////////////////////////////////////////////////////

   fe_pc_gen u_pc_gen (
      .clk         (clk),
      .rst_n       (rst_n),
      .redirect    (pc_redirect),
      .fetch_hold  (fetch_hold),
      .fetch_ready (fetch_ready),
      .fetch_pc    (fetch_pc),
      .fetch_valid (fetch_valid),
      .start_slot  (start_slot)
   );

   fe_instr_store u_instr_store (
      .clk          (clk),
      .rst_n        (rst_n),
      .prog_we      (prog_we),
      .prog_addr    (prog_addr),
      .prog_data    (prog_data),
      .fetch_pc     (fetch_pc),
      .fetch_valid  (fetch_valid),
      .start_slot   (start_slot),
      .fetch_ready  (fetch_ready),
      .squash       (squash),
      .flush        (flush),
      .bundle       (st_bundle),
      .bundle_valid (st_valid),
      .bundle_ready (st_ready)
   );

   fe_jump_resolve u_jump_resolve (
      .clk            (clk),
      .rst_n          (rst_n),
      .flush          (flush),
      .in_bundle      (st_bundle),
      .in_valid       (st_valid),
      .in_ready       (st_ready),
      .out_bundle     (jr_bundle),
      .out_valid      (jr_valid),
      .out_ready      (jr_ready),
      .redirect       (jr_redirect),
      .squash         (squash),
      .fetch_hold     (fetch_hold),
      .base_req_valid (base_req_valid),
      .base_req_reg   (base_req_reg),
      .base_rsp_valid (base_rsp_valid),
      .base_rsp_data  (base_rsp_data)
   );

   fe_issue_buffer u_issue_buffer (
      .clk        (clk),
      .rst_n      (rst_n),
      .flush      (flush),
      .in_bundle  (jr_bundle),
      .in_valid   (jr_valid),
      .in_ready   (jr_ready),
      .out_bundle (out_bundle),
      .out_valid  (out_valid),
      .out_ready  (out_ready)
   );

endmodule

// File: design/fe_issue_buffer.sv
`timescale 1ns/1ps

module fe_issue_buffer (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  flush,
   input  fe_pkg::fetch_bundle_t in_bundle,
   input  logic                  in_valid,
   output logic                  in_ready,
   output fe_pkg::fetch_bundle_t out_bundle,
   output logic                  out_valid,
   input  logic                  out_ready
);
   import fe_pkg::*;

   fetch_bundle_t entry_q [buf_depth];
   // one-bit pointers for two entries
   logic          wr_q;
   logic          rd_q;
   logic [1:0]    count_q;
   logic          push;
   logic          pop;

   //////////////////////////////////////////////////////////////////////
   // handshake
   //////////////////////////////////////////////////////////////////////

   // ready while an entry is free
   assign in_ready   = (count_q != 2'(buf_depth));
   assign out_valid  = (count_q != 2'd0);
   // head entry is stable until popped
   assign out_bundle = entry_q[rd_q];

   // flush beats a same-cycle push
   assign push = in_valid && in_ready && !flush;
   assign pop  = out_valid && out_ready;

   //////////////////////////////////////////////////////////////////////
   // pointers and occupancy
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_q    <= 1'b0;
         rd_q    <= 1'b0;
         count_q <= '0;
      end else if (flush) begin
         wr_q    <= 1'b0;
         rd_q    <= 1'b0;
         count_q <= '0;
      end else begin
         if (push) begin
            wr_q <= !wr_q;
         end
         if (pop) begin
            rd_q <= !rd_q;
         end
         count_q <= count_q + 2'(push) - 2'(pop);
      end
   end

   // storage
   always_ff @(posedge clk) begin
      if (push) begin
         entry_q[wr_q] <= in_bundle;
      end
   end

endmodule

// File: design/fe_jump_resolve.sv
`timescale 1ns/1ps

module fe_jump_resolve (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          flush,
   input  fe_pkg::fetch_bundle_t         in_bundle,
   input  logic                          in_valid,
   output logic                          in_ready,
   output fe_pkg::fetch_bundle_t         out_bundle,
   output logic                          out_valid,
   input  logic                          out_ready,
   output fe_pkg::redirect_t             redirect,
   output logic                          squash,
   output logic                          fetch_hold,
   output logic                          base_req_valid,
   output logic [fe_pkg::reg_idx_w-1:0]  base_req_reg,
   input  logic                          base_rsp_valid,
   input  logic [fe_pkg::addr_w-1:0]     base_rsp_data
);
   import fe_pkg::*;

   jr_state_e              state_q;
   jump_kind_e             kind [fetch_width];
   jump_kind_e             first_kind;
   logic [slot_w-1:0]      first_idx;
   logic [fetch_width-1:0] keep;
   logic [insn_w-1:0]      first_insn;
   logic [addr_w-1:0]      imm_ext;
   logic [addr_w-1:0]      imm_target;
   logic [addr_w-1:0]      reg_off_ext;
   // saved register jump fields
   logic [addr_w-1:0]      off_q;
   logic [reg_idx_w-1:0]   reg_q;
   logic                   run;
   logic                   fire;
   logic                   take_imm;
   logic                   take_reg;
   logic                   rsp_hit;

   //////////////////////////////////////////////////////////////////////
   // slot classification
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      for (int i = 0; i < fetch_width; i++) begin
         // dead slots never count as jumps
         if (!in_bundle.mask[i] ||
             opcode_e'(in_bundle.insn[i][op_lo +: op_w]) != op_jump) begin
            kind[i] = jk_none;
         end else if (in_bundle.insn[i][kind_bit]) begin
            kind[i] = jk_reg;
         end else begin
            kind[i] = jk_imm;
         end
      end
   end

   // oldest jump wins, scan down so the lowest slot sticks
   always_comb begin
      first_kind = jk_none;
      first_idx  = '0;
      for (int i = fetch_width - 1; i >= 0; i--) begin
         if (kind[i] != jk_none) begin
            first_kind = kind[i];
            first_idx  = slot_w'(i);
         end
      end
   end

   // slots younger than the jump are killed
   always_comb begin
      for (int i = 0; i < fetch_width; i++) begin
         keep[i] = (first_kind == jk_none) || (i <= int'(first_idx));
      end
   end

   //////////////////////////////////////////////////////////////////////
   // targets
   //////////////////////////////////////////////////////////////////////

   assign first_insn = in_bundle.insn[first_idx];

   // sign extended offsets
   assign imm_ext = {{(addr_w - imm_off_w){first_insn[imm_off_lo + imm_off_w - 1]}},
                     first_insn[imm_off_lo +: imm_off_w]};
   assign reg_off_ext = {{(addr_w - reg_off_w){first_insn[reg_off_lo + reg_off_w - 1]}},
                         first_insn[reg_off_lo +: reg_off_w]};

   // slot pc plus one plus offset
   assign imm_target = in_bundle.pc + addr_w'(first_idx) + addr_w'(1) + imm_ext;

   //////////////////////////////////////////////////////////////////////
   // handshake and side outputs
   //////////////////////////////////////////////////////////////////////

   assign run       = (state_q == jr_run);
   // nothing accepted while waiting on a base
   assign out_valid = in_valid && run;
   assign in_ready  = out_ready && run;
   assign fire      = in_valid && in_ready;
   // redirect only when the jump bundle is actually handed over
   assign take_imm  = fire && (first_kind == jk_imm);
   assign take_reg  = fire && (first_kind == jk_reg);
   assign rsp_hit   = !run && base_rsp_valid;

   always_comb begin
      out_bundle      = in_bundle;
      out_bundle.mask = in_bundle.mask & keep;
   end

   assign redirect.valid = take_imm || rsp_hit;
   assign redirect.pc    = rsp_hit ? (base_rsp_data + off_q) : imm_target;

   // drop sequential fetches behind any taken jump and during the wait
   assign squash         = take_imm || take_reg || !run;
   assign fetch_hold     = !run;
   assign base_req_valid = !run;
   assign base_req_reg   = reg_q;

   //////////////////////////////////////////////////////////////////////
   // base wait FSM
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= jr_run;
      end else if (flush) begin
         state_q <= jr_run;
      end else begin
         unique case (state_q)
            jr_run: begin
               if (take_reg) begin
                  state_q <= jr_wait_base;
               end
            end
            jr_wait_base: begin
               // response is a single pulse, wait length open
               if (base_rsp_valid) begin
                  state_q <= jr_run;
               end
            end
            default: state_q <= jr_run;
         endcase
      end
   end

   // captured at handover of the register jump
   always_ff @(posedge clk) begin
      if (take_reg) begin
         off_q <= reg_off_ext;
         reg_q <= first_insn[reg_idx_lo +: reg_idx_w];
      end
   end

endmodule

// File: design/fe_instr_store.sv
`timescale 1ns/1ps

module fe_instr_store (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          prog_we,
   input  logic [fe_pkg::addr_w-1:0]     prog_addr,
   input  logic [fe_pkg::insn_w-1:0]     prog_data,
   input  logic [fe_pkg::addr_w-1:0]     fetch_pc,
   input  logic                          fetch_valid,
   input  logic [fe_pkg::slot_w-1:0]     start_slot,
   output logic                          fetch_ready,
   input  logic                          squash,
   input  logic                          flush,
   output fe_pkg::fetch_bundle_t         bundle,
   output logic                          bundle_valid,
   input  logic                          bundle_ready
);
   import fe_pkg::*;

   logic [insn_w-1:0] mem [store_depth];
   fetch_bundle_t     rd_bundle;
   logic              kill;
   logic              take;

   //////////////////////////////////////////////////////////////////////
   // word memory, one word written per cycle
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (prog_we) begin
         // address wraps inside the store
         mem[prog_addr[store_aw-1:0]] <= prog_data;
      end
   end

   // four-wide read of the aligned line
   always_comb begin
      rd_bundle.pc = fetch_pc;
      for (int i = 0; i < fetch_width; i++) begin
         rd_bundle.insn[i] = mem[{fetch_pc[store_aw-1:slot_w], slot_w'(i)}];
         // slots below a redirect target are dead
         rd_bundle.mask[i] = (i >= int'(start_slot));
      end
   end

   //////////////////////////////////////////////////////////////////////
   // output register
   //////////////////////////////////////////////////////////////////////

   assign kill        = squash || flush;
   // free when empty or draining this cycle
   assign fetch_ready = !bundle_valid || bundle_ready;
   // a kill also drops the read accepted at the same edge
   assign take        = fetch_valid && fetch_ready && !kill;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bundle_valid <= 1'b0;
      end else if (kill) begin
         bundle_valid <= 1'b0;
      end else if (fetch_ready) begin
         bundle_valid <= fetch_valid;
      end
   end

   // payload only
   always_ff @(posedge clk) begin
      if (take) begin
         bundle <= rd_bundle;
      end
   end

endmodule

// File: design/fe_pc_gen.sv
`timescale 1ns/1ps

module fe_pc_gen (
   input  logic                          clk,
   input  logic                          rst_n,
   input  fe_pkg::redirect_t             redirect,
   input  logic                          fetch_hold,
   input  logic                          fetch_ready,
   output logic [fe_pkg::addr_w-1:0]     fetch_pc,
   output logic                          fetch_valid,
   output logic [fe_pkg::slot_w-1:0]     start_slot
);
   import fe_pkg::*;

   // aligned bundle address
   logic [addr_w-1:0] pc_q;
   // slot offset of the last redirect target
   logic [slot_w-1:0] start_q;
   logic              advance;

   //////////////////////////////////////////////////////////////////////
   // fetch request
   //////////////////////////////////////////////////////////////////////

   // no fetch while the resolve stage waits on a base
   assign fetch_valid = !fetch_hold;
   assign advance     = fetch_valid && fetch_ready;

   //////////////////////////////////////////////////////////////////////
   // address register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc_q    <= '0;
         start_q <= '0;
      end else if (redirect.valid) begin
         // redirect wins over advance
         // target aligned down, low bits kept for slot masking
         pc_q    <= {redirect.pc[addr_w-1:slot_w], {slot_w{1'b0}}};
         start_q <= redirect.pc[slot_w-1:0];
      end else if (advance) begin
         // next bundle is always full
         pc_q    <= pc_q + addr_w'(fetch_width);
         start_q <= '0;
      end
   end

   assign fetch_pc   = pc_q;
   assign start_slot = start_q;

endmodule

// File: design/fe_pkg.sv
package fe_pkg;

   //////////////////////////////////////////////////////////////////////
   // sizes
   //////////////////////////////////////////////////////////////////////

   // one address is one instruction word
   localparam int addr_w      = 16;
   localparam int insn_w      = 16;
   // slots per bundle, bundles aligned to this
   localparam int fetch_width = 4;
   localparam int store_depth = 256;
   localparam int reg_idx_w   = 4;
   localparam int slot_w      = $clog2(fetch_width);
   localparam int store_aw    = $clog2(store_depth);
   // issue buffer entries
   localparam int buf_depth   = 2;

   //////////////////////////////////////////////////////////////////////
   // instruction format
   //////////////////////////////////////////////////////////////////////

   // opcode sits in the top bits
   localparam int op_w       = 4;
   localparam int op_lo      = insn_w - op_w;
   // jump kind select, 0 immediate, 1 register
   localparam int kind_bit   = 0;
   // immediate jump, signed offset in [11:2]
   localparam int imm_off_lo = 2;
   localparam int imm_off_w  = 10;
   // register jump, index in [11:8], signed offset in [7:2]
   localparam int reg_idx_lo = 8;
   localparam int reg_off_lo = 2;
   localparam int reg_off_w  = 6;

   typedef enum logic [op_w-1:0] {
      op_jump = 4'b1111
   } opcode_e;

   // per-slot classification
   typedef enum logic [1:0] {
      jk_none,
      jk_imm,
      jk_reg
   } jump_kind_e;

   typedef enum logic {
      jr_run,
      jr_wait_base
   } jr_state_e;

   // bundle pc is aligned, mask bit i set means slot i is live
   typedef struct packed {
      logic [addr_w-1:0]                  pc;
      logic [fetch_width-1:0][insn_w-1:0] insn;
      logic [fetch_width-1:0]             mask;
   } fetch_bundle_t;

   typedef struct packed {
      logic              valid;
      logic [addr_w-1:0] pc;
   } redirect_t;

endpackage
